/* hdl/mcd_host_pkg.sv */
/*
 * Shared types and constants for the Mega-CD host glue.
 * Covers the drive link words, the CDC data word, the region encoding,
 * the host download indices, the keyboard codes and the header offsets.
 */
package mcd_host_pkg;

	////////////////////
	// Drive link types
	////////////////////

	// Status as seen by the CD core, dm sits just above the status word
	typedef struct packed {
		logic        dm;
		logic [39:0] stat;
	} cdd_status_t;

	typedef logic [39:0] cdd_command_t;
	typedef logic [15:0] cdc_word_t;

	// Bit 48 toggle, 47..40 pad, 39..0 payload
	typedef logic [48:0] cd_link_t;

	typedef enum logic [1:0] {
		JP = 2'd0,
		US = 2'd1,
		EU = 2'd2
	} region_t;

	////////////////////
	// Host download indices, compared on index bits 5..0
	////////////////////
	localparam logic [5:0] DL_BIOS_MAX = 6'd1;
	localparam logic [5:0] DL_CDC_DATA = 6'd2;
	localparam logic [5:0] DL_CDC_SUB  = 6'd3;
	localparam logic [5:0] DL_CART     = 6'd4;

	// Keyboard codes for the region override
	localparam logic [8:0] KEY_F1 = 9'h005;
	localparam logic [8:0] KEY_F2 = 9'h006;
	localparam logic [8:0] KEY_F3 = 9'h004;

	// Region byte in the cartridge header
	localparam logic [24:0] HDR_REGION_ADDR = 25'h1F0;

	localparam int HOLD_CYCLES_DEF = 8;

endpackage

/* hdl/strobe_stretch.sv */
/*
 * Latches a payload on an event and holds a valid level afterwards.
 * The hold lasts HOLD_CYCLES cycles and restarts on every new event,
 * so a burst of events keeps the level up past the last one.
 */
`timescale 1ns/1ps

module strobe_stretch #(
	parameter type payload_t = logic,
	parameter int HOLD_CYCLES = 8
) (
	input  logic     clk_sys,
	input  logic     arst_n,
	input  logic     event_in,
	input  payload_t payload_in,
	output payload_t payload_out,
	output logic     hold
);

	localparam int CNT_W = $clog2(HOLD_CYCLES + 1);

	// Cycles left in the current hold window
	logic [CNT_W-1:0] cnt;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			cnt         <= '0;
			payload_out <= '0;
		end else if (event_in) begin
			cnt         <= CNT_W'(HOLD_CYCLES);
			payload_out <= payload_in;
		end else if (cnt != '0) begin
			cnt <= cnt - 1'b1;
		end
	end

	// High from the event edge until the count runs out
	assign hold = (cnt != '0);

endmodule

/* hdl/cd_interface.sv */
/*
 * CD drive mailbox and CDC data feeder.
 * Status words from the host are picked up on a toggle and announced by
 * a stretched receive pulse; commands go back on a rising send level.
 * Downloaded data words are held for the CDC with a steered write strobe.
 */
`timescale 1ns/1ps

module cd_interface #(
	parameter int HOLD_CYCLES = 8
) (
	input  logic                       clk_sys,
	input  logic                       arst_n,

	// Host side of the drive link
	input  mcd_host_pkg::cd_link_t     cd_out,
	output mcd_host_pkg::cd_link_t     cd_in,

	// CD core side of the drive link
	input  mcd_host_pkg::cdd_command_t cdd_comm,
	input  logic                       cdd_send,
	output mcd_host_pkg::cdd_status_t  cdd_stat,
	output logic                       cdd_rec,

	// Host download stream
	input  logic                       ioctl_download,
	input  logic [7:0]                 ioctl_index,
	input  logic                       ioctl_wr,
	input  mcd_host_pkg::cdc_word_t    ioctl_data,

	// CDC feed
	output mcd_host_pkg::cdc_word_t    cdc_data,
	output logic                       cdc_dat_wr,
	output logic                       cdc_sc_wr
);

	import mcd_host_pkg::*;

	logic        toggle_last;
	logic        stat_event;
	cdd_status_t status_in;
	logic        send_last;
	logic        send_rise;
	logic        cdc_hold;
	logic        dl_cdc_data;
	logic        dl_cdc_sub;

	////////////////////
	// Status receive
	////////////////////

	// Host marks a new status by flipping bit 48
	assign stat_event = (cd_out[48] != toggle_last);
	assign status_in  = {cd_out[40], cd_out[39:0]};

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			toggle_last <= 1'b1;
		end else begin
			toggle_last <= cd_out[48];
		end
	end

	strobe_stretch #(
		.payload_t   (cdd_status_t),
		.HOLD_CYCLES (HOLD_CYCLES)
	) status_stretch (
		.clk_sys     (clk_sys),
		.arst_n      (arst_n),
		.event_in    (stat_event),
		.payload_in  (status_in),
		.payload_out (cdd_stat),
		.hold        (cdd_rec)
	);

	////////////////////
	// Command send
	////////////////////
	assign send_rise = cdd_send & ~send_last;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			send_last <= 1'b0;
			cd_in     <= '0;
		end else begin
			send_last <= cdd_send;
			// New command with a flipped toggle for the host
			if (send_rise) begin
				cd_in <= {~cd_in[48], 8'h00, cdd_comm};
			end
		end
	end

	////////////////////
	// CDC data feed
	////////////////////
	strobe_stretch #(
		.payload_t   (cdc_word_t),
		.HOLD_CYCLES (HOLD_CYCLES)
	) cdc_stretch (
		.clk_sys     (clk_sys),
		.arst_n      (arst_n),
		.event_in    (ioctl_wr),
		.payload_in  (ioctl_data),
		.payload_out (cdc_data),
		.hold        (cdc_hold)
	);

	// Steer by the live download index
	assign dl_cdc_data = ioctl_download & (ioctl_index[5:0] == DL_CDC_DATA);
	assign dl_cdc_sub  = ioctl_download & (ioctl_index[5:0] == DL_CDC_SUB);

	assign cdc_dat_wr = cdc_hold & dl_cdc_data;
	assign cdc_sc_wr  = cdc_hold & dl_cdc_sub;

endmodule

/* hdl/region_select.sv */
/*
 * Console region selector.
 * Scans the cartridge header region byte during a ROM download and turns
 * the header-ready edges into a region request; F1, F2 and F3 override it.
 */
`timescale 1ns/1ps

module region_select (
	input  logic                  clk_sys,
	input  logic                  arst_n,
	input  logic                  ioctl_download,
	input  logic [7:0]            ioctl_index,
	input  logic                  ioctl_wr,
	input  logic [24:0]           ioctl_addr,
	input  logic [15:0]           ioctl_data,
	input  logic [10:0]           ps2_key,
	output mcd_host_pkg::region_t region_req,
	output logic                  region_set
);

	import mcd_host_pkg::*;

	logic       rom_download;
	logic       rom_dl_last;
	logic       rom_dl_rise;
	logic       rom_dl_fall;
	logic       hdr_write;
	logic       hdr_j;
	logic       hdr_u;
	logic       hdr_ready;
	logic       ready_last;
	logic       key_last;
	logic       key_event;
	logic       key_pressed;
	logic [8:0] key_code;

	// BIOS or cartridge image
	assign rom_download = ioctl_download &
		((ioctl_index[5:0] <= DL_BIOS_MAX) | (ioctl_index[5:0] == DL_CART));

	assign rom_dl_rise = rom_download & ~rom_dl_last;
	assign rom_dl_fall = ~rom_download & rom_dl_last;
	assign hdr_write   = ioctl_wr & rom_download & (ioctl_addr == HDR_REGION_ADDR);

	////////////////////
	// Header scan
	////////////////////
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			rom_dl_last <= 1'b0;
			hdr_j       <= 1'b0;
			hdr_u       <= 1'b0;
			hdr_ready   <= 1'b0;
		end else begin
			rom_dl_last <= rom_download;
			if (rom_dl_rise) begin
				hdr_j     <= 1'b0;
				hdr_u     <= 1'b0;
				hdr_ready <= 1'b0;
			end
			if (rom_dl_fall) begin
				hdr_ready <= 1'b0;
			end
			// A header write in the same cycle overrides the clears
			if (hdr_write) begin
				if (ioctl_data[7:0] == "J") begin
					hdr_j <= 1'b1;
				end else if (ioctl_data[7:0] == "U") begin
					hdr_u <= 1'b1;
				end
				hdr_ready <= 1'b1;
			end
		end
	end

	////////////////////
	// Region request
	////////////////////
	assign key_event   = (ps2_key[10] != key_last);
	assign key_pressed = ps2_key[9];
	assign key_code    = ps2_key[8:0];

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			key_last   <= 1'b0;
			ready_last <= 1'b0;
			region_req <= JP;
			region_set <= 1'b0;
		end else begin
			key_last   <= ps2_key[10];
			ready_last <= hdr_ready;

			if (key_event) begin
				case (key_code)
					KEY_F1: begin
						region_req <= JP;
						region_set <= key_pressed;
					end
					KEY_F2: begin
						region_req <= US;
						region_set <= key_pressed;
					end
					KEY_F3: begin
						region_req <= EU;
						region_set <= key_pressed;
					end
					default: ;
				endcase
			end

			// Header events come last so they beat a key in the same cycle
			if (hdr_ready & ~ready_last) begin
				region_set <= 1'b1;
				if (hdr_u) begin
					region_req <= US;
				end else if (hdr_j) begin
					region_req <= JP;
				end else begin
					region_req <= EU;
				end
			end
			if (~hdr_ready & ready_last) begin
				region_set <= 1'b0;
			end
		end
	end

endmodule

/* hdl/mcd_host_glue.sv */
/*
 * Top level of the Mega-CD host glue.
 * Joins the drive mailbox with CDC feeder and the region selector,
 * both fed from the same host download stream.
 */
`timescale 1ns/1ps

module mcd_host_glue #(
	parameter int HOLD_CYCLES = mcd_host_pkg::HOLD_CYCLES_DEF
) (
	input  logic                       clk_sys,
	input  logic                       arst_n,

	// Drive link
	input  mcd_host_pkg::cd_link_t     cd_out,
	output mcd_host_pkg::cd_link_t     cd_in,
	input  mcd_host_pkg::cdd_command_t cdd_comm,
	input  logic                       cdd_send,
	output mcd_host_pkg::cdd_status_t  cdd_stat,
	output logic                       cdd_rec,

	// Host download and keyboard
	input  logic                       ioctl_download,
	input  logic [7:0]                 ioctl_index,
	input  logic                       ioctl_wr,
	input  logic [24:0]                ioctl_addr,
	input  mcd_host_pkg::cdc_word_t    ioctl_data,
	input  logic [10:0]                ps2_key,

	// CDC feed and region
	output mcd_host_pkg::cdc_word_t    cdc_data,
	output logic                       cdc_dat_wr,
	output logic                       cdc_sc_wr,
	output mcd_host_pkg::region_t      region_req,
	output logic                       region_set
);

	cd_interface #(
		.HOLD_CYCLES    (HOLD_CYCLES)
	) cd_interface_inst (
		.clk_sys        (clk_sys),
		.arst_n         (arst_n),
		.cd_out         (cd_out),
		.cd_in          (cd_in),
		.cdd_comm       (cdd_comm),
		.cdd_send       (cdd_send),
		.cdd_stat       (cdd_stat),
		.cdd_rec        (cdd_rec),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_data     (ioctl_data),
		.cdc_data       (cdc_data),
		.cdc_dat_wr     (cdc_dat_wr),
		.cdc_sc_wr      (cdc_sc_wr)
	);

	region_select region_select_inst (
		.clk_sys        (clk_sys),
		.arst_n         (arst_n),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_data     (ioctl_data),
		.ps2_key        (ps2_key),
		.region_req     (region_req),
		.region_set     (region_set)
	);

endmodule

/* test/mcd_host_glue_assert.sv */
/*
 * Concurrent assertions on the host glue outputs.
 * Bound to every instance of the top level.
 */
`timescale 1ns/1ps

module mcd_host_glue_assert (
	input logic                   clk_sys,
	input logic                   arst_n,
	input logic                   cdc_dat_wr,
	input logic                   cdc_sc_wr,
	input mcd_host_pkg::region_t  region_req,
	input mcd_host_pkg::cd_link_t cd_in
);

	// One CDC channel at a time
	strobe_excl: assert property (@(posedge clk_sys) disable iff (!arst_n)
		!(cdc_dat_wr && cdc_sc_wr))
		else $error("CDC data and subcode strobes are high together");

	region_legal: assert property (@(posedge clk_sys) disable iff (!arst_n)
		region_req != 2'd3)
		else $error("region request holds the unused code 3");

	// Pad between toggle and command
	link_pad: assert property (@(posedge clk_sys) disable iff (!arst_n)
		cd_in[47:40] == 8'h00)
		else $error("drive link pad bits are not zero");

endmodule

bind mcd_host_glue mcd_host_glue_assert mcd_host_glue_assert_inst (
	.clk_sys    (clk_sys),
	.arst_n     (arst_n),
	.cdc_dat_wr (cdc_dat_wr),
	.cdc_sc_wr  (cdc_sc_wr),
	.region_req (region_req),
	.cd_in      (cd_in)
);

/* test/tb_mcd_host_glue.sv */
/*
 * Testbench for the Mega-CD host glue top level.
 * Drives random drive-link, download and keyboard traffic, runs a cycle
 * model alongside the DUT and compares every output each cycle.
 */
`timescale 1ns/1ps

module tb_mcd_host_glue;

	import mcd_host_pkg::*;

	localparam int HOLD       = HOLD_CYCLES_DEF;
	localparam int CLK_PERIOD = 40;
	localparam int N_STAT     = 80;
	localparam int N_CMD      = 80;
	localparam int N_CDC      = 400;
	localparam int N_HDR      = 30;
	localparam int N_KEY      = 100;
	// Worst case cycles per test, plus reset
	localparam int TOTAL_CYCLES = 8 + N_STAT * 13 + N_CMD * 6 + N_CDC + 1 +
		N_HDR * 18 + N_KEY * 4;
	localparam int TIMEOUT_NS = (TOTAL_CYCLES + 200) * CLK_PERIOD;

	logic         clk_sys;
	logic         arst_n;
	cd_link_t     cd_out;
	cd_link_t     cd_in;
	cdd_command_t cdd_comm;
	logic         cdd_send;
	cdd_status_t  cdd_stat;
	logic         cdd_rec;
	logic         ioctl_download;
	logic [7:0]   ioctl_index;
	logic         ioctl_wr;
	logic [24:0]  ioctl_addr;
	cdc_word_t    ioctl_data;
	logic [10:0]  ps2_key;
	cdc_word_t    cdc_data;
	logic         cdc_dat_wr;
	logic         cdc_sc_wr;
	region_t      region_req;
	logic         region_set;

	integer seed;

	// Model state
	logic         m_tog;
	cdd_status_t  m_stat;
	int           m_rec_cnt;
	logic         m_send;
	cd_link_t     m_cd_in;
	cdc_word_t    m_cdc_data;
	int           m_cdc_cnt;
	logic         m_rom_last;
	logic         m_hdr_j;
	logic         m_hdr_u;
	logic         m_hdr_ready;
	logic         m_ready_last;
	logic         m_key_last;
	region_t      m_region;
	logic         m_region_set;

	mcd_host_glue #(
		.HOLD_CYCLES    (HOLD)
	) mcd_host_glue_inst (
		.clk_sys        (clk_sys),
		.arst_n         (arst_n),
		.cd_out         (cd_out),
		.cd_in          (cd_in),
		.cdd_comm       (cdd_comm),
		.cdd_send       (cdd_send),
		.cdd_stat       (cdd_stat),
		.cdd_rec        (cdd_rec),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_data     (ioctl_data),
		.ps2_key        (ps2_key),
		.cdc_data       (cdc_data),
		.cdc_dat_wr     (cdc_dat_wr),
		.cdc_sc_wr      (cdc_sc_wr),
		.region_req     (region_req),
		.region_set     (region_set)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	initial begin
		#(TIMEOUT_NS);
		$display("timeout: the tests did not finish within the expected time");
		stop_run();
	end

	////////////////////
	// Helpers
	////////////////////
	function automatic logic [63:0] rand64();
		rand64 = {$random(seed), $random(seed)};
	endfunction

	function automatic int rand_range(input int n);
		rand_range = int'({$random(seed)} % n);
	endfunction

	task automatic stop_run();
		$display("Testbench failed");
		$fatal(1, "stopping at the first failure");
	endtask

	task automatic report_mismatch(input string name, input logic [63:0] exp,
			input logic [63:0] act);
		$display("error: %s expected %h actual %h", name, exp, act);
		stop_run();
	endtask

	task automatic check_link(input cd_link_t exp, input cd_link_t act);
		if (act !== exp) report_mismatch("cd_in", exp, act);
	endtask

	task automatic check_status(input cdd_status_t exp, input logic exp_rec,
			input cdd_status_t act, input logic act_rec);
		if (act.stat !== exp.stat) report_mismatch("cdd_stat", exp.stat, act.stat);
		else if (act.dm !== exp.dm) report_mismatch("cdd_dm", exp.dm, act.dm);
		else if (act_rec !== exp_rec) report_mismatch("cdd_rec", exp_rec, act_rec);
	endtask

	task automatic check_cdc(input cdc_word_t exp, input logic exp_dat, input logic exp_sc,
			input cdc_word_t act, input logic act_dat, input logic act_sc);
		if (act !== exp) report_mismatch("cdc_data", exp, act);
		else if (act_dat !== exp_dat) report_mismatch("cdc_dat_wr", exp_dat, act_dat);
		else if (act_sc !== exp_sc) report_mismatch("cdc_sc_wr", exp_sc, act_sc);
	endtask

	task automatic check_region(input region_t exp, input logic exp_set,
			input region_t act, input logic act_set);
		if (act !== exp) report_mismatch("region_req", exp, act);
		else if (act_set !== exp_set) report_mismatch("region_set", exp_set, act_set);
	endtask

	////////////////////
	// Reference model
	////////////////////
	task automatic model_reset();
		m_tog        = 1'b1;
		m_stat       = '0;
		m_rec_cnt    = 0;
		m_send       = 1'b0;
		m_cd_in      = '0;
		m_cdc_data   = '0;
		m_cdc_cnt    = 0;
		m_rom_last   = 1'b0;
		m_hdr_j      = 1'b0;
		m_hdr_u      = 1'b0;
		m_hdr_ready  = 1'b0;
		m_ready_last = 1'b0;
		m_key_last   = 1'b0;
		m_region     = JP;
		m_region_set = 1'b0;
	endtask

	// Next state from the inputs sampled at the coming rising edge
	task automatic model_step();
		logic rom;
		logic hdr_wr;
		rom = ioctl_download && (ioctl_index[5:0] <= DL_BIOS_MAX ||
			ioctl_index[5:0] == DL_CART);
		hdr_wr = ioctl_wr && rom && ioctl_addr == HDR_REGION_ADDR;

		if (cd_out[48] != m_tog) begin
			m_stat    = {cd_out[40], cd_out[39:0]};
			m_rec_cnt = HOLD;
		end else if (m_rec_cnt > 0) begin
			m_rec_cnt--;
		end
		m_tog = cd_out[48];

		if (cdd_send && !m_send) m_cd_in = {~m_cd_in[48], 8'h00, cdd_comm};
		m_send = cdd_send;

		if (ioctl_wr) begin
			m_cdc_data = ioctl_data;
			m_cdc_cnt  = HOLD;
		end else if (m_cdc_cnt > 0) begin
			m_cdc_cnt--;
		end

		// Keys first, header edges win
		if (ps2_key[10] != m_key_last) begin
			if (ps2_key[8:0] == KEY_F1) m_region = JP;
			if (ps2_key[8:0] == KEY_F2) m_region = US;
			if (ps2_key[8:0] == KEY_F3) m_region = EU;
			if (ps2_key[8:0] inside {KEY_F1, KEY_F2, KEY_F3}) m_region_set = ps2_key[9];
		end
		m_key_last = ps2_key[10];
		if (m_hdr_ready && !m_ready_last) begin
			m_region_set = 1'b1;
			m_region     = m_hdr_u ? US : (m_hdr_j ? JP : EU);
		end
		if (!m_hdr_ready && m_ready_last) m_region_set = 1'b0;
		m_ready_last = m_hdr_ready;

		if (rom && !m_rom_last) begin
			m_hdr_j     = 1'b0;
			m_hdr_u     = 1'b0;
			m_hdr_ready = 1'b0;
		end
		if (!rom && m_rom_last) m_hdr_ready = 1'b0;
		if (hdr_wr) begin
			m_hdr_ready = 1'b1;
			if (ioctl_data[7:0] == "J") m_hdr_j = 1'b1;
			else if (ioctl_data[7:0] == "U") m_hdr_u = 1'b1;
		end
		m_rom_last = rom;
	endtask

	task automatic check_outputs();
		logic live;
		live = (m_cdc_cnt > 0) && ioctl_download;
		check_link(m_cd_in, cd_in);
		check_status(m_stat, m_rec_cnt > 0, cdd_stat, cdd_rec);
		check_cdc(m_cdc_data, live && ioctl_index[5:0] == DL_CDC_DATA,
			live && ioctl_index[5:0] == DL_CDC_SUB, cdc_data, cdc_dat_wr, cdc_sc_wr);
		check_region(m_region, m_region_set, region_req, region_set);
	endtask

	// Inputs set at a falling edge are checked at the next one
	task automatic step_cycle();
		model_step();
		@(negedge clk_sys);
		check_outputs();
	endtask

	////////////////////
	// Stimulus
	////////////////////
	task automatic drive_status_words();
		logic [63:0] r;
		for (int i = 0; i < N_STAT; i++) begin
			r = rand64();
			cd_out = {~cd_out[48], 7'h00, r[40:0]};
			step_cycle();
			// Payload moves without a toggle
			repeat (1 + rand_range(12)) begin
				r = rand64();
				cd_out[47:0] = r[47:0];
				step_cycle();
			end
		end
	endtask

	task automatic send_commands();
		logic [63:0] r;
		for (int i = 0; i < N_CMD; i++) begin
			cdd_send = ~cdd_send;
			repeat (1 + rand_range(6)) begin
				r = rand64();
				cdd_comm = r[39:0];
				step_cycle();
			end
		end
	endtask

	task automatic feed_cdc_words();
		logic [63:0] r;
		ioctl_index = {2'b00, DL_CDC_DATA};
		for (int i = 0; i < N_CDC; i++) begin
			r = rand64();
			if (r[63:61] == 3'd0) begin
				case (rand_range(3))
					0: ioctl_index = {r[7:6], DL_CDC_DATA};
					1: ioctl_index = {r[7:6], DL_CDC_SUB};
					default: ioctl_index = r[7:0];
				endcase
			end
			ioctl_download = (r[60:57] != 4'd0);
			ioctl_wr       = (r[56:55] == 2'd0);
			ioctl_addr     = r[48:24];
			ioctl_data     = r[15:0];
			step_cycle();
		end
		ioctl_wr       = 1'b0;
		ioctl_download = 1'b0;
		step_cycle();
	endtask

	task automatic download_headers();
		logic [63:0] r;
		logic [7:0]  hdr_byte;
		for (int i = 0; i < N_HDR; i++) begin
			ioctl_download = 1'b0;
			ioctl_wr       = 1'b0;
			repeat (2) step_cycle();
			r = rand64();
			case (rand_range(3))
				0: ioctl_index = {r[7:6], 6'd0};
				1: ioctl_index = {r[7:6], DL_BIOS_MAX};
				default: ioctl_index = {r[7:6], DL_CART};
			endcase
			ioctl_download = 1'b1;
			repeat (rand_range(4)) begin
				r = rand64();
				ioctl_wr   = 1'b1;
				ioctl_addr = r[24:0];
				ioctl_data = r[47:32];
				step_cycle();
				ioctl_wr = 1'b0;
				step_cycle();
			end
			r = rand64();
			case (rand_range(3))
				0: hdr_byte = "J";
				1: hdr_byte = "U";
				default: hdr_byte = r[7:0];
			endcase
			ioctl_addr = HDR_REGION_ADDR;
			ioctl_data = {r[15:8], hdr_byte};
			ioctl_wr   = 1'b1;
			step_cycle();
			ioctl_wr = 1'b0;
			repeat (2 + rand_range(4)) step_cycle();
			// End of download drops region_set
			ioctl_download = 1'b0;
			repeat (3) step_cycle();
		end
	endtask

	task automatic press_keys();
		logic [63:0] r;
		logic [8:0]  code;
		for (int i = 0; i < N_KEY; i++) begin
			r = rand64();
			case (rand_range(4))
				0: code = KEY_F1;
				1: code = KEY_F2;
				2: code = KEY_F3;
				default: code = r[8:0];
			endcase
			ps2_key = {~ps2_key[10], r[9], code};
			step_cycle();
			repeat (rand_range(3)) step_cycle();
		end
	endtask

	initial begin
		seed           = 32'hac08_999f;
		arst_n         = 1'b0;
		cd_out         = {1'b1, 48'h0};
		cdd_comm       = '0;
		cdd_send       = 1'b0;
		ioctl_download = 1'b0;
		ioctl_index    = '0;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_data     = '0;
		ps2_key        = '0;
		model_reset();
		repeat (8) @(negedge clk_sys);
		arst_n = 1'b1;
		// Everything zero straight out of reset
		check_outputs();
		drive_status_words();
		send_commands();
		feed_cdc_words();
		download_headers();
		press_keys();
		$display("Testbench passed");
		$finish;
	end

endmodule

/* flist.f */
hdl/mcd_host_pkg.sv
hdl/strobe_stretch.sv
hdl/cd_interface.sv
hdl/region_select.sv
hdl/mcd_host_glue.sv
test/mcd_host_glue_assert.sv
test/tb_mcd_host_glue.sv

/* Bender.yml */
package:
  name: mcd_host_glue

sources:
  - hdl/mcd_host_pkg.sv
  - hdl/strobe_stretch.sv
  - hdl/cd_interface.sv
  - hdl/region_select.sv
  - hdl/mcd_host_glue.sv
  - target: test
    files:
      - test/mcd_host_glue_assert.sv
      - test/tb_mcd_host_glue.sv
